// ==== fsync_pkg.sv ====
// fractal sync package: widths, level constants and request/response types of the 2x2 network
`default_nettype none

package fsync_pkg;

  // aggregate mask widths shrink by one bit per tree level
  localparam int unsigned IN_AGGR_WIDTH  = 3;
  localparam int unsigned ITL_AGGR_WIDTH = 2;
  localparam int unsigned OUT_AGGR_WIDTH = 1;

  localparam int unsigned ID_WIDTH   = 2;
  localparam int unsigned LVL_WIDTH  = 1;
  localparam int unsigned N_CU_PORTS = 4;

  typedef logic [ID_WIDTH-1:0]  sync_id_t;
  typedef logic [LVL_WIDTH-1:0] sync_lvl_t;

  // request from a compute unit into a level-0 node
  typedef struct packed {
    logic                     req;
    logic [IN_AGGR_WIDTH-1:0] aggr;
    sync_id_t                 id;
  } fsync_in_req_t;

  // request leaving the level-1 stage towards the outside
  typedef struct packed {
    logic                      req;
    logic [OUT_AGGR_WIDTH-1:0] aggr;
    sync_id_t                  id;
  } fsync_out_req_t;

  // wake response, used on every level of the tree
  typedef struct packed {
    logic      wake;
    logic      error;
    sync_lvl_t lvl;
    sync_id_t  id;
  } fsync_rsp_t;

  // a barrier closed inside a node, or an error, with the ports to wake
  typedef struct packed {
    logic       valid;
    logic [1:0] mask;
    logic       error;
    sync_id_t   id;
  } fsync_local_t;

  // bit 0 of the mask selects a join at this level
  typedef enum logic [1:0] {
    JOIN,
    PASS,
    ERR
  } req_class_e;

endpackage

`default_nettype wire

// ==== fsync_req_decode.sv ====
// request decode: registers the two child requests of a node and classifies their masks
`timescale 1ns/10ps
`default_nettype none

module fsync_req_decode #(
  parameter int unsigned AGGR_WIDTH = 3
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [1:0]                            req_i,
  input  logic [1:0][AGGR_WIDTH-1:0]            aggr_i,
  input  fsync_pkg::sync_id_t [1:0]             id_i,
  output logic [1:0]                            vld_o,
  output fsync_pkg::req_class_e                 class_o [2],
  output logic [1:0][AGGR_WIDTH-2:0]            aggr_o,
  output fsync_pkg::sync_id_t [1:0]             id_o
);

  fsync_pkg::req_class_e cls_d [2];

  // a set bit 0 asks for a barrier at this node, higher bits ask for one further up
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if (aggr_i[p][0]) begin
        cls_d[p] = fsync_pkg::JOIN;
      end else if (|aggr_i[p][AGGR_WIDTH-1:1]) begin
        cls_d[p] = fsync_pkg::PASS;
      end else begin
        cls_d[p] = fsync_pkg::ERR;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_o <= '0;
    end else begin
      vld_o <= req_i;
    end
  end

  // the mask leaves decode without bit 0, the next stage only sees the levels above
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < 2; p++) begin
      if (req_i[p]) begin
        class_o[p] <= cls_d[p];
        aggr_o[p]  <= aggr_i[p][AGGR_WIDTH-1:1];
        id_o[p]    <= id_i[p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== fsync_barrier_table.sv ====
// barrier table: per-id pending bits of a node, pairs arrivals into local closes or upward requests
`timescale 1ns/10ps
`default_nettype none

module fsync_barrier_table #(
  parameter int unsigned AGGR_WIDTH = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [1:0]                 vld_i,
  input  fsync_pkg::req_class_e      class_i [2],
  input  logic [1:0][AGGR_WIDTH-2:0] aggr_i,
  input  fsync_pkg::sync_id_t [1:0]  id_i,
  output fsync_pkg::fsync_local_t    local_o,
  output logic                       up_req_o,
  output logic [AGGR_WIDTH-2:0]      up_aggr_o,
  output fsync_pkg::sync_id_t        up_id_o,
  output logic [1:0]                 up_mask_o
);

  localparam int unsigned N_IDS = 2**fsync_pkg::ID_WIDTH;

  // one result of the table, either a local wake or a request to the parent
  typedef struct packed {
    logic                  vld;
    logic                  up;
    logic                  err;
    logic [1:0]            ports;
    logic [AGGR_WIDTH-2:0] aggr;
    fsync_pkg::sync_id_t   id;
  } evt_t;

  logic [N_IDS-1:0][1:0] pend_q, pend_d;
  logic                  pair;
  evt_t                  evt [2];
  evt_t                  evt_a, evt_b;
  evt_t                  slot, hold_d, hold_q, out_q;

  // both ports join the same id in one cycle
  assign pair = &vld_i && class_i[0] == fsync_pkg::JOIN && class_i[1] == fsync_pkg::JOIN &&
                id_i[0] == id_i[1];

  always_comb begin
    pend_d = pend_q;
    for (int p = 0; p < 2; p++) begin
      evt[p]       = '0;
      evt[p].aggr  = aggr_i[p];
      evt[p].id    = id_i[p];
      evt[p].ports = 2'b01 << p;
      if (vld_i[p]) begin
        case (class_i[p])
          fsync_pkg::PASS: begin
            evt[p].vld = 1'b1;
            evt[p].up  = 1'b1;
          end
          fsync_pkg::JOIN: begin
            if (pend_q[id_i[p]][p]) begin
              // second arrival while this port still waits on the id
              evt[p].vld = 1'b1;
              evt[p].err = 1'b1;
            end else if (pend_q[id_i[p]][1-p] || pair) begin
              // barrier meets, it closes here when no mask bit is left
              evt[p].vld           = 1'b1;
              evt[p].up            = |aggr_i[p];
              evt[p].ports         = 2'b11;
              pend_d[id_i[p]][1-p] = 1'b0;
            end else begin
              pend_d[id_i[p]][p] = 1'b1;
            end
          end
          default: begin
            evt[p].vld = 1'b1;
            evt[p].err = 1'b1;
          end
        endcase
      end
    end
  end

  // equal results of both ports merge, otherwise port B waits one cycle in the hold register
  always_comb begin
    evt_a = evt[0];
    evt_b = evt[1];
    if (evt_a.vld && evt_b.vld && evt_a.up == evt_b.up && evt_a.err == evt_b.err &&
        evt_a.id == evt_b.id) begin
      evt_a.ports = evt_a.ports | evt_b.ports;
      evt_b.vld   = 1'b0;
    end
    // while B is held both ports wait for a wake, so at most one new result shows up
    if (hold_q.vld) begin
      slot   = hold_q;
      hold_d = evt_a.vld ? evt_a : evt_b;
    end else if (evt_a.vld) begin
      slot   = evt_a;
      hold_d = evt_b;
    end else begin
      slot   = evt_b;
      hold_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
      hold_q <= '0;
      out_q  <= '0;
    end else begin
      pend_q <= pend_d;
      hold_q <= hold_d;
      out_q  <= slot;
    end
  end

  assign local_o.valid = out_q.vld && !out_q.up;
  assign local_o.mask  = out_q.ports;
  assign local_o.error = out_q.err;
  assign local_o.id    = out_q.id;

  assign up_req_o  = out_q.vld && out_q.up;
  assign up_aggr_o = out_q.aggr;
  assign up_id_o   = out_q.id;
  assign up_mask_o = out_q.ports;

endmodule

`default_nettype wire

// ==== fsync_rsp_route.sv ====
// wake router: tracks ports waiting on upward requests and drives registered wakes to the children
`timescale 1ns/10ps
`default_nettype none

module fsync_rsp_route #(
  parameter fsync_pkg::sync_lvl_t LVL_VALUE = '0
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  fsync_pkg::fsync_local_t     local_i,
  input  logic                        up_req_i,
  input  fsync_pkg::sync_id_t         up_id_i,
  input  logic [1:0]                  up_mask_i,
  input  fsync_pkg::fsync_rsp_t       up_rsp_i,
  output fsync_pkg::fsync_rsp_t [1:0] rsp_o
);

  localparam int unsigned N_IDS = 2**fsync_pkg::ID_WIDTH;

  logic [N_IDS-1:0][1:0]       wait_q, wait_d;
  logic [1:0]                  up_ports;
  fsync_pkg::fsync_rsp_t [1:0] rsp_d;

  // a parent wake for an id nobody waits on selects no port
  assign up_ports = up_rsp_i.wake ? wait_q[up_rsp_i.id] : 2'b00;

  always_comb begin
    wait_d = wait_q;
    if (up_rsp_i.wake) begin
      wait_d[up_rsp_i.id] = 2'b00;
    end
    if (up_req_i) begin
      wait_d[up_id_i] = wait_d[up_id_i] | up_mask_i;
    end
  end

  // the one-outstanding rule keeps local and parent wakes apart on a port
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rsp_d[p] = '0;
      if (local_i.valid && local_i.mask[p]) begin
        rsp_d[p].wake  = 1'b1;
        rsp_d[p].error = local_i.error;
        rsp_d[p].lvl   = LVL_VALUE;
        rsp_d[p].id    = local_i.id;
      end else if (up_ports[p]) begin
        rsp_d[p] = up_rsp_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= '0;
      rsp_o  <= '0;
    end else begin
      wait_q <= wait_d;
      rsp_o  <= rsp_d;
    end
  end

endmodule

`default_nettype wire

// ==== fsync_2x2.sv ====
// 2x2 fractal sync network: horizontal and vertical level-0 pairs joined by one level-1 node each
`timescale 1ns/10ps
`default_nettype none

module fsync_2x2 (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  fsync_pkg::fsync_in_req_t  h_req_i [fsync_pkg::N_CU_PORTS],
  input  fsync_pkg::fsync_in_req_t  v_req_i [fsync_pkg::N_CU_PORTS],
  output fsync_pkg::fsync_rsp_t     h_rsp_o [fsync_pkg::N_CU_PORTS],
  output fsync_pkg::fsync_rsp_t     v_rsp_o [fsync_pkg::N_CU_PORTS],
  output fsync_pkg::fsync_out_req_t h_out_req_o,
  output fsync_pkg::fsync_out_req_t v_out_req_o,
  input  fsync_pkg::fsync_rsp_t     h_out_rsp_i,
  input  fsync_pkg::fsync_rsp_t     v_out_rsp_i
);

  // level-0 nodes 0 and 1 are horizontal, 2 and 3 vertical
  logic [3:0][1:0]                               l0_req;
  logic [3:0][1:0][fsync_pkg::IN_AGGR_WIDTH-1:0] l0_aggr;
  fsync_pkg::sync_id_t [3:0][1:0]                l0_id;
  fsync_pkg::fsync_rsp_t [3:0][1:0]              l0_rsp;
  logic [3:0]                                    l0_up_req;
  logic [3:0][fsync_pkg::ITL_AGGR_WIDTH-1:0]     l0_up_aggr;
  fsync_pkg::sync_id_t [3:0]                     l0_up_id;
  fsync_pkg::fsync_rsp_t [3:0]                   l0_up_rsp;
  logic [1:0]                                    l1_up_req;
  logic [1:0][fsync_pkg::OUT_AGGR_WIDTH-1:0]     l1_up_aggr;
  fsync_pkg::sync_id_t [1:0]                     l1_up_id;
  fsync_pkg::fsync_rsp_t [1:0]                   l1_out_rsp;

  // horizontal pairs are CU 2k and 2k+1, vertical pairs are transposed to CU k and k+2
  for (genvar k = 0; k < 2; k++) begin : gen_cu_map
    assign l0_req[k]    = {h_req_i[2*k+1].req, h_req_i[2*k].req};
    assign l0_aggr[k]   = {h_req_i[2*k+1].aggr, h_req_i[2*k].aggr};
    assign l0_id[k]     = {h_req_i[2*k+1].id, h_req_i[2*k].id};
    assign h_rsp_o[2*k]   = l0_rsp[k][0];
    assign h_rsp_o[2*k+1] = l0_rsp[k][1];

    assign l0_req[k+2]  = {v_req_i[k+2].req, v_req_i[k].req};
    assign l0_aggr[k+2] = {v_req_i[k+2].aggr, v_req_i[k].aggr};
    assign l0_id[k+2]   = {v_req_i[k+2].id, v_req_i[k].id};
    assign v_rsp_o[k]   = l0_rsp[k+2][0];
    assign v_rsp_o[k+2] = l0_rsp[k+2][1];
  end

  for (genvar n = 0; n < 4; n++) begin : gen_l0_node
    logic [1:0]                                    vld;
    fsync_pkg::req_class_e                         cls [2];
    logic [1:0][fsync_pkg::IN_AGGR_WIDTH-2:0]      aggr;
    fsync_pkg::sync_id_t [1:0]                     id;
    fsync_pkg::fsync_local_t                       loc;
    logic [1:0]                                    up_mask;

    fsync_req_decode #(.AGGR_WIDTH(fsync_pkg::IN_AGGR_WIDTH)) i_decode (
      .clk_i, .rst_n_i,
      .req_i(l0_req[n]), .aggr_i(l0_aggr[n]), .id_i(l0_id[n]),
      .vld_o(vld), .class_o(cls), .aggr_o(aggr), .id_o(id)
    );

    fsync_barrier_table #(.AGGR_WIDTH(fsync_pkg::IN_AGGR_WIDTH)) i_table (
      .clk_i, .rst_n_i,
      .vld_i(vld), .class_i(cls), .aggr_i(aggr), .id_i(id),
      .local_o(loc), .up_req_o(l0_up_req[n]), .up_aggr_o(l0_up_aggr[n]),
      .up_id_o(l0_up_id[n]), .up_mask_o(up_mask)
    );

    fsync_rsp_route #(.LVL_VALUE(1'b0)) i_route (
      .clk_i, .rst_n_i,
      .local_i(loc), .up_req_i(l0_up_req[n]), .up_id_i(l0_up_id[n]), .up_mask_i(up_mask),
      .up_rsp_i(l0_up_rsp[n]), .rsp_o(l0_rsp[n])
    );
  end

  assign l1_out_rsp[0] = h_out_rsp_i;
  assign l1_out_rsp[1] = v_out_rsp_i;

  // level-1 node d joins level-0 nodes 2d and 2d+1
  for (genvar d = 0; d < 2; d++) begin : gen_l1_node
    logic [1:0]                                    vld;
    fsync_pkg::req_class_e                         cls [2];
    logic [1:0][fsync_pkg::ITL_AGGR_WIDTH-2:0]     aggr;
    fsync_pkg::sync_id_t [1:0]                     id;
    fsync_pkg::fsync_local_t                       loc;
    logic [1:0]                                    up_mask;

    fsync_req_decode #(.AGGR_WIDTH(fsync_pkg::ITL_AGGR_WIDTH)) i_decode (
      .clk_i, .rst_n_i,
      .req_i(l0_up_req[2*d+:2]), .aggr_i(l0_up_aggr[2*d+:2]), .id_i(l0_up_id[2*d+:2]),
      .vld_o(vld), .class_o(cls), .aggr_o(aggr), .id_o(id)
    );

    fsync_barrier_table #(.AGGR_WIDTH(fsync_pkg::ITL_AGGR_WIDTH)) i_table (
      .clk_i, .rst_n_i,
      .vld_i(vld), .class_i(cls), .aggr_i(aggr), .id_i(id),
      .local_o(loc), .up_req_o(l1_up_req[d]), .up_aggr_o(l1_up_aggr[d]),
      .up_id_o(l1_up_id[d]), .up_mask_o(up_mask)
    );

    fsync_rsp_route #(.LVL_VALUE(1'b1)) i_route (
      .clk_i, .rst_n_i,
      .local_i(loc), .up_req_i(l1_up_req[d]), .up_id_i(l1_up_id[d]), .up_mask_i(up_mask),
      .up_rsp_i(l1_out_rsp[d]), .rsp_o(l0_up_rsp[2*d+:2])
    );
  end

  assign h_out_req_o.req  = l1_up_req[0];
  assign h_out_req_o.aggr = l1_up_aggr[0];
  assign h_out_req_o.id   = l1_up_id[0];
  assign v_out_req_o.req  = l1_up_req[1];
  assign v_out_req_o.aggr = l1_up_aggr[1];
  assign v_out_req_o.id   = l1_up_id[1];

endmodule

`default_nettype wire

// ==== tb_fsync_2x2.sv ====
// testbench for the 2x2 fractal sync network, replays request and wake records from a file
`timescale 1ns/10ps
`default_nettype none

module tb_fsync_2x2;

  localparam int unsigned N_RECS     = 128;
  localparam int unsigned RST_CYCLES = 5;

  logic                      clk;
  logic                      rst_n;
  fsync_pkg::fsync_in_req_t  h_req [fsync_pkg::N_CU_PORTS];
  fsync_pkg::fsync_in_req_t  v_req [fsync_pkg::N_CU_PORTS];
  fsync_pkg::fsync_rsp_t     h_rsp [fsync_pkg::N_CU_PORTS];
  fsync_pkg::fsync_rsp_t     v_rsp [fsync_pkg::N_CU_PORTS];
  fsync_pkg::fsync_out_req_t h_out_req;
  fsync_pkg::fsync_out_req_t v_out_req;
  fsync_pkg::fsync_rsp_t     h_out_rsp;
  fsync_pkg::fsync_rsp_t     v_out_rsp;

  logic [31:0] recs [N_RECS];
  logic [31:0] exp_q [$];
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit;
  int unsigned test_errors;
  int unsigned tests_passed;
  int unsigned tests_failed;

  fsync_2x2 fsync_2x2_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .h_req_i(h_req), .v_req_i(v_req), .h_rsp_o(h_rsp), .v_rsp_o(v_rsp),
    .h_out_req_o(h_out_req), .v_out_req_o(v_out_req),
    .h_out_rsp_i(h_out_rsp), .v_out_rsp_i(v_out_rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the records did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic clear_inputs();
    for (int p = 0; p < fsync_pkg::N_CU_PORTS; p++) begin
      h_req[p] = '0;
      v_req[p] = '0;
    end
    h_out_rsp = '0;
    v_out_rsp = '0;
  endtask

  // a request record drives one CU port, a response record one outer port
  task automatic drive_record(input logic [31:0] rec);
    fsync_pkg::fsync_in_req_t req;
    fsync_pkg::fsync_rsp_t    rsp;
    req = {1'b1, rec[18:16], rec[13:12]};
    rsp = {1'b1, 1'b0, rec[16], rec[13:12]};
    if (rec[31:28] == 4'h2) begin
      if (rec[24]) begin
        v_out_rsp = rsp;
      end else begin
        h_out_rsp = rsp;
      end
    end else if (rec[24]) begin
      v_req[rec[21:20]] = req;
    end else begin
      h_req[rec[21:20]] = req;
    end
  endtask

  task automatic compare(input string name, input logic [4:0] got, input logic [4:0] exp,
                         input logic [4:0] care);
    assert ((got & care) == exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got & care, exp);
      test_errors++;
    end
  endtask

  // without an expectation only the wake or req bit is checked, it has to stay low
  task automatic check_cycle(input int unsigned k);
    logic [4:0] exp_rsp [2][fsync_pkg::N_CU_PORTS];
    logic [3:0] exp_out [2];
    logic [4:0] got;
    for (int d = 0; d < 2; d++) begin
      exp_out[d] = '0;
      for (int p = 0; p < fsync_pkg::N_CU_PORTS; p++) begin
        exp_rsp[d][p] = '0;
      end
    end
    foreach (exp_q[i]) begin
      if ({24'd0, exp_q[i][7:0]} == k) begin
        if (exp_q[i][31:28] == 4'h3) begin
          exp_rsp[exp_q[i][24]][exp_q[i][21:20]] =
            {1'b1, exp_q[i][8], exp_q[i][16], exp_q[i][13:12]};
        end else begin
          exp_out[exp_q[i][24]] = {1'b1, exp_q[i][16], exp_q[i][13:12]};
        end
      end
    end
    for (int d = 0; d < 2; d++) begin
      for (int p = 0; p < fsync_pkg::N_CU_PORTS; p++) begin
        got = (d == 0) ? h_rsp[p] : v_rsp[p];
        compare($sformatf("%s_rsp_o[%0d]", d ? "v" : "h", p), got, exp_rsp[d][p],
                exp_rsp[d][p][4] ? 5'h1f : 5'h10);
      end
      got = (d == 0) ? {1'b0, h_out_req} : {1'b0, v_out_req};
      compare(d ? "v_out_req_o" : "h_out_req_o", got, {1'b0, exp_out[d]},
              exp_out[d][3] ? 5'h0f : 5'h08);
    end
  endtask

  initial begin
    int unsigned r;
    int unsigned n;
    int unsigned steps;
    logic [31:0] rec;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    n = 0;
    clear_inputs();
    rst_n = 1'b0;
    foreach (recs[i]) begin
      recs[i] = 32'hf000_0000;
    end
    $readmemh("fsync_input.txt", recs);
    // the run lasts the reset plus every step of the records
    cycle_limit = RST_CYCLES + 50;
    for (r = 0; r < N_RECS; r++) begin
      if (recs[r][31:28] == 4'h5) begin
        cycle_limit += {24'd0, recs[r][7:0]};
      end
    end
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    r = 0;
    while (r < N_RECS && recs[r][31:28] != 4'hf) begin
      rec = recs[r];
      case (rec[31:28])
        4'h1, 4'h2: drive_record(rec);
        4'h3, 4'h4: exp_q.push_back(rec);
        4'h5: begin
          steps = {24'd0, rec[7:0]};
          for (int unsigned k = 1; k <= steps; k++) begin
            @(posedge clk);
            #2;
            if (k == 1) begin
              clear_inputs();
            end
            check_cycle(k);
          end
          exp_q.delete();
        end
        4'h6: begin
          n++;
          if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed", n);
          end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", n, test_errors);
          end
          test_errors = 0;
        end
        default: begin
          $display("record %0d has the unknown kind %h", r, rec[31:28]);
          test_errors++;
        end
      endcase
      r++;
    end
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed != 0 && test_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
fsync_pkg.sv
fsync_req_decode.sv
fsync_barrier_table.sv
fsync_rsp_route.sv
fsync_2x2.sv
tb_fsync_2x2.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the 2x2 fractal sync testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_fsync_2x2 -Mdir obj_dir -f compile.f \
  && ./obj_dir/Vtb_fsync_2x2 | tee /dev/stderr | grep -q -F -e '** PASS **' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== fsync_input.txt ====
// one hex word per record, digits from left: kind dir port aggr/lvl id err, last two are cycles
// kinds 1 cu request, 2 outer response, 3 expect wake, 4 expect outer request, 5 step, 6 end, f eof
// test 1: horizontal pair closes at level 0
10010000 10110000 30000003 30100003 50000006 60000000
// test 2: vertical pairs wait for their transposed partners, then close at level 0
11011000 11111000 50000005
11211000 11311000 31001003 31101003 31201003 31301003 50000006 60000000
// test 3: four horizontal joins close at level 1 without an outer request
10032000 10132000 10232000 10332000 30012006 30112006 30212006 30312006 50000009 60000000
// test 4: outer barrier, outer wake, then an outer wake for an id nobody waits on
10073000 10173000 10273000 10373000 40013004 50000006
20013000 30013002 30113002 30213002 30313002 50000004
20010000 50000004 60000000
// test 5: zero mask and a second arrival on a pending port give error wakes
10201000 30201103 50000005
10312000 50000005
10312000 30302103 50000005
10212000 30202003 30302003 50000005 60000000
f0000000
